// File: verilog.f
hdl/dsp16_ctrl_pkg.sv
hdl/branch_decode.sv
hdl/data_decode.sv
hdl/instr_issue.sv
hdl/dsp16_ctrl.sv
verification/dsp16_ctrl_asserts.sv
verification/tb_dsp16_ctrl.sv

// File: Makefile
# Verilator build and run for the DSP16 decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_dsp16_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST OK" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_dsp16_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DSP16 decoder testbench
// Directed tests of strobes, conditions,
// two-cycle words and the sticky fault
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_dsp16_ctrl
    import dsp16_ctrl_pkg::*;
();

    localparam int     CLK_PERIOD     = 20;
    localparam int     TIMEOUT_CYCLES = 400;  // Directed tests need about 60 cycles
    localparam instr_t FILLER         = 16'h1000;  // Short immediate, single cycle
    localparam instr_t CON_PREFIX     = {OP_CON_BR, 11'h000};  // Bit 10 low

    logic          clk;
    logic          rst;
    logic          cen;
    instr_t        rom_dout;
    logic          con_result;
    branch_ctrl_t  branch;
    data_ctrl_t    data;
    instr_fields_t fields;
    logic          pc_halt;
    logic          no_int;
    logic          fault;

    int    cycle_count;
    int    check_count;
    int    error_count;
    int    errors_at_start;
    string test_name;

    dsp16_ctrl dut (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .rom_dout   (rom_dout),
        .con_result (con_result),
        .branch     (branch),
        .data       (data),
        .fields     (fields),
        .pc_halt    (pc_halt),
        .no_int     (no_int),
        .fault      (fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH test=%s signal=%s expected=%0h actual=%0h",
                     test_name, what, expected, actual);
        end
    endtask

    // Word goes in 2 ns after an edge, its decode is registered on the next one
    task automatic feed(input instr_t word, input logic con);
        rom_dout   = word;
        con_result = con;
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        $display("test %s: %0d errors", test_name, error_count - errors_at_start);
    endtask

    // Y post-modify mode for the low two bits of a RAM transfer
    function automatic yaau_ctrl_t expected_y_mode(input logic [1:0] m);
        yaau_ctrl_t y;
        y           = '0;
        y.post_load = 1'b1;
        if (m == 2'd3) begin
            y.step_sel = 1'b1;
        end else begin
            y.inc_sel = (m == 2'd0) ? 2'd1 : (m == 2'd1) ? 2'd2 : 2'd0;
        end
        return y;
    endfunction

    task automatic test_reset_state();
        start_test("reset_state");
        check("branch", 64'd0, 64'(branch));
        check("data", 64'd0, 64'(data));
        check("fields", 64'd0, 64'(fields));
        check("pc_halt", 64'd0, 64'(pc_halt));
        check("fault", 64'd0, 64'(fault));
        check("no_int", 64'd1, 64'(no_int));
        finish_test();
    endtask

    task automatic test_short_imm();
        logic [31:0] rnd;
        instr_t      word;
        start_test("short_imm");
        rnd  = $urandom;
        word = {4'b0001, rnd[11:0]};
        feed(word, 1'b0);
        check("short_load", 64'd1, 64'(data.load.short_load));
        check("short_imm", 64'(word[8:0]), 64'(fields.short_imm));
        check("r_field", 64'({~word[11], word[10:9]}), 64'(fields.regs.r_field));
        check("no_int", 64'd1, 64'(no_int));
        feed({OP_IF_CON, 11'h000}, 1'b0);
        check("short_load next", 64'd0, 64'(data.load.short_load));
        finish_test();
    endtask

    task automatic test_long_imm();
        logic [31:0] rnd;
        instr_t      word;
        instr_t      imm;
        start_test("long_imm");
        rnd  = $urandom;
        word = {OP_R_IMM, 1'b0, 3'd0, rnd[6:0]};  // Destination 0 is the Y unit
        imm  = {4'b0001, rnd[23:12]};             // Looks like a short immediate
        feed(word, 1'b0);
        check("long_load", 64'd1, 64'(data.load.long_load));
        check("long_imm", 64'(word), 64'(fields.long_imm));
        check("pc_halt", 64'd0, 64'(pc_halt));
        check("no_int", 64'd0, 64'(no_int));
        feed(imm, 1'b0);
        check("short_load second word", 64'd0, 64'(data.load.short_load));
        check("long_imm second word", 64'(imm), 64'(fields.long_imm));
        check("no_int second word", 64'd1, 64'(no_int));
        finish_test();
    endtask

    task automatic test_conditions();
        logic [31:0] rnd;
        start_test("conditions");
        rnd = $urandom;
        feed(CON_PREFIX, 1'b0);
        check("con_check", 64'd1, 64'(branch.con_check));
        feed({OP_GOTO_JA, rnd[10:0]}, 1'b0);    // Condition false
        check("goto_ja false", 64'd0, 64'(branch.goto_ja));
        check("pc_halt false", 64'd1, 64'(pc_halt));
        feed(FILLER, 1'b0);
        feed(CON_PREFIX, 1'b0);
        feed({OP_GOTO_JA, rnd[21:11]}, 1'b1);   // Condition true
        check("goto_ja true", 64'd1, 64'(branch.goto_ja));
        check("pc_halt true", 64'd1, 64'(pc_halt));
        feed(FILLER, 1'b0);
        // iret ignores the failed condition, a plain return does not
        feed(CON_PREFIX, 1'b0);
        feed({OP_GOTO_B, 3'd1, 8'h00}, 1'b0);
        check("goto_b iret", 64'd1, 64'(branch.goto_b));
        check("iret", 64'd1, 64'(branch.iret));
        feed(FILLER, 1'b0);
        feed(CON_PREFIX, 1'b0);
        feed({OP_GOTO_B, 3'd0, 8'h00}, 1'b0);
        check("goto_b return", 64'd0, 64'(branch.goto_b));
        feed(FILLER, 1'b0);
        finish_test();
    endtask

    task automatic test_ram_moves();
        int         mode;
        int         store;
        opcode_t    op;
        logic [1:0] m;
        start_test("ram_moves");
        for (mode = 0; mode < 4; mode++) begin
            for (store = 0; store < 2; store++) begin
                m  = mode[1:0];
                op = (store != 0) ? OP_Y_R : OP_R_Y;
                feed({op, 9'h000, m}, 1'b0);
                check("ram_we", 64'(store), 64'(data.load.ram_we));
                check("yaau", 64'(expected_y_mode(m)), 64'(data.yaau));
                check("pc_halt", 64'd1, 64'(pc_halt));
                feed(FILLER, 1'b0);   // Dropped second word
            end
        end
        finish_test();
    endtask

    task automatic test_fault();
        start_test("fault");
        check("fault before", 64'd0, 64'(fault));
        feed({5'b11110, 11'h000}, 1'b0);
        check("fault set", 64'd1, 64'(fault));
        feed(FILLER, 1'b0);
        feed({OP_IF_CON, 11'h000}, 1'b0);
        feed(CON_PREFIX, 1'b0);
        check("fault held", 64'd1, 64'(fault));
        apply_reset();
        check("fault after reset", 64'd0, 64'(fault));
        check("no_int after reset", 64'd1, 64'(no_int));
        feed({5'b01110, 11'h000}, 1'b0);   // Dropped pt family
        check("fault dropped opcode", 64'd1, 64'(fault));
        apply_reset();
        finish_test();
    endtask

    initial begin
        void'($urandom(44));
        rst         = 1'b1;
        cen         = 1'b1;
        rom_dout    = FILLER;
        con_result  = 1'b0;
        check_count = 0;
        error_count = 0;
        apply_reset();
        test_reset_state();
        test_short_imm();
        test_long_imm();
        test_conditions();
        test_ram_moves();
        test_fault();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verification/dsp16_ctrl_asserts.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue-stage assertions
// Second-cycle gating, no_int
// and the sticky fault
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dsp16_ctrl_asserts
    import dsp16_ctrl_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         cen,
    input logic         two_cycle,
    input seq_ctrl_t    br_seq,
    input seq_ctrl_t    data_seq,
    input branch_ctrl_t branch,
    input data_ctrl_t   data,
    input logic         pc_halt,
    input logic         no_int,
    input logic         fault
);

    // Nothing issues from the dropped second word
    second_cycle_quiet: assert property (@(posedge clk) disable iff (rst)
        $past(two_cycle && cen) |-> (branch == '0 && data == '0 && !pc_halt))
        else $error("strobe issued in the second cycle of a two-cycle instruction");

    // Interrupts blocked for the cycle after a two-cycle word only
    no_int_follows_request: assert property (@(posedge clk) disable iff (rst)
        $past(cen && !rst) |->
            no_int == ($past(two_cycle) || !$past(br_seq.two_cycle || data_seq.two_cycle)))
        else $error("no_int does not follow the two-cycle request");

    // Set by an unclaimed issuing word, then held until reset
    fault_sets_and_holds: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |->
            fault == ($past(fault) ||
                      $past(cen && !two_cycle && !(br_seq.hit || data_seq.hit))))
        else $error("fault does not follow the unclaimed-word rule");

endmodule

bind instr_issue dsp16_ctrl_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .cen       (cen),
    .two_cycle (two_cycle),
    .br_seq    (br_seq),
    .data_seq  (data_seq),
    .branch    (branch),
    .data      (data),
    .pc_halt   (pc_halt),
    .no_int    (no_int),
    .fault     (fault)
);

// File: hdl/dsp16_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DSP16 instruction decoder
// Branch and data decoders feeding
// the registered issue stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dsp16_ctrl
    import dsp16_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,
    input  instr_t        rom_dout,
    input  logic          con_result,  // From the previous condition check
    output branch_ctrl_t  branch,
    output data_ctrl_t    data,
    output instr_fields_t fields,
    output logic          pc_halt,
    output logic          no_int,
    output logic          fault
);

    branch_ctrl_t br_req;
    seq_ctrl_t    br_seq;
    data_ctrl_t   data_req;
    reg_sel_t     regs_req;
    logic [1:0]   a_sel;
    seq_ctrl_t    data_seq;

    branch_decode u_branch_decode (
        .instr (rom_dout),
        .br    (br_req),
        .seq   (br_seq)
    );

    data_decode u_data_decode (
        .instr (rom_dout),
        .data  (data_req),
        .regs  (regs_req),
        .a_sel (a_sel),
        .seq   (data_seq)
    );

    instr_issue u_instr_issue (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .instr      (rom_dout),
        .br         (br_req),
        .data_in    (data_req),
        .regs_in    (regs_req),
        .a_sel      (a_sel),
        .br_seq     (br_seq),
        .data_seq   (data_seq),
        .con_result (con_result),
        .branch     (branch),
        .data       (data),
        .fields     (fields),
        .pc_halt    (pc_halt),
        .no_int     (no_int),
        .fault      (fault)
    );

endmodule

// File: hdl/instr_issue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue stage
// Applies branch conditions, tracks
// two-cycle words, registers outputs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_issue
    import dsp16_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,
    input  instr_t        instr,
    input  branch_ctrl_t  br,
    input  data_ctrl_t    data_in,
    input  reg_sel_t      regs_in,
    input  logic [1:0]    a_sel,
    input  seq_ctrl_t     br_seq,
    input  seq_ctrl_t     data_seq,
    input  logic          con_result,
    output branch_ctrl_t  branch,
    output data_ctrl_t    data,
    output instr_fields_t fields,
    output logic          pc_halt,
    output logic          no_int,
    output logic          fault
);

    logic two_cycle;   // Current word is the second half of a two-cycle instruction
    logic issue;
    logic claimed;
    logic con_ok;

    assign issue   = ~two_cycle;
    assign claimed = br_seq.hit | data_seq.hit;
    assign con_ok  = ~branch.con_check | con_result; // Uses the previous issued check
    assign no_int  = ~two_cycle;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            branch    <= '0;
            data      <= '0;
            fields    <= '0;
            pc_halt   <= 1'b0;
            two_cycle <= 1'b0;
            fault     <= 1'b0;
        end else if (cen) begin
            fields.t_field       <= instr[15:11];
            fields.c_field       <= instr[4:0];
            fields.y_field       <= instr[3:2];
            fields.a_field       <= issue ? a_sel : 2'd0;
            fields.dau_op_fields <= instr[10:5];
            fields.short_imm     <= instr[8:0];
            fields.i_field       <= instr[11:0];
            fields.long_imm      <= instr;
            if (issue && data_seq.hit) begin
                fields.regs <= regs_in;
            end

            if (issue) begin
                branch.goto_ja   <= br.goto_ja & con_ok;
                branch.call_ja   <= br.call_ja & con_ok;
                branch.goto_b    <= br.goto_b & (con_ok | br.iret);
                branch.con_check <= br.con_check;
                branch.iret      <= br.iret;
                data             <= data_in;
                pc_halt          <= br_seq.pc_halt | data_seq.pc_halt;
                two_cycle        <= br_seq.two_cycle | data_seq.two_cycle;
                if (!claimed) begin
                    fault <= 1'b1; // Sticky until reset
                end
            end else begin
                // Second fetched word is dropped
                branch    <= '0;
                data      <= '0;
                pc_halt   <= 1'b0;
                two_cycle <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/data_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data decoder
// Register loads, RAM transfers,
// accumulator moves and F1/F2 forms
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module data_decode
    import dsp16_ctrl_pkg::*;
(
    input  instr_t     instr,
    output data_ctrl_t data,
    output reg_sel_t   regs,
    output logic [1:0] a_sel,
    output seq_ctrl_t  seq
);

    opcode_t    op;
    yaau_ctrl_t y_mode;   // Post-modify from bits 1:0
    logic [2:0] y_or_yl;  // 1 selects y, 2 selects yl

    assign op      = instr[15:11];
    assign y_or_yl = instr[4] ? 3'd1 : 3'd2;

    always_comb begin
        y_mode           = '0;
        y_mode.post_load = 1'b1;
        case (instr[1:0])
            2'd0: y_mode.inc_sel  = 2'd1; // *rN
            2'd1: y_mode.inc_sel  = 2'd2; // *rN++
            2'd2: y_mode.inc_sel  = 2'd0; // *rN--
            2'd3: y_mode.step_sel = 1'b1; // *rN++j
            default: ;
        endcase
    end

    always_comb begin
        data    = '0;
        regs    = '0;
        a_sel   = 2'd0;
        seq     = '0;
        seq.hit = 1'b1;
        case (op)
            OP_SHORT_IMM, OP_SHORT_IMM | 5'd1: begin // j, k, rb, re
                data.load.short_load = 1'b1;
                regs.r_field         = instr[11:9] ^ 3'b100;
            end

            OP_AT_R: begin
                regs.r_field           = instr[6:4];
                regs.rsel              = instr[8:6];
                data.dau.dau_rmux_load = 1'b1;
                data.dau.pdx_read      = 1'b1;
                data.dau.st_a0h        =  instr[10];
                data.dau.st_a1h        = ~instr[10];
                seq.pc_halt            = 1'b1;
                seq.two_cycle          = 1'b1;
            end

            OP_R_A0, OP_R_A1: begin
                regs.r_field            = instr[6:4];
                a_sel                   = {1'b1, instr[12]};
                data.dau.acc_sel        = 1'b1;
                data.dau.dau_acc_load   = instr[8:7] == 2'b10; // DAU register
                data.load.acc_load      = instr[8:7] == 2'b00; // Y unit register
                data.load.xaau_acc_load = instr[8:7] == 2'b01; // X unit register
                seq.pc_halt             = 1'b1;
                seq.two_cycle           = 1'b1;
            end

            OP_R_IMM: begin
                // Destination unit in bits 9:7
                data.load.long_load     = instr[9:7] == 3'd0;
                data.load.xaau_imm_load = instr[9:7] == 3'd1;
                data.dau.dau_imm_load   = instr[9:7] == 3'd2;
                regs.r_field            = instr[6:4];
                seq.two_cycle           = 1'b1;  // Second word is the immediate
            end

            OP_R_Y, OP_Y_R: begin
                if (op == OP_R_Y && !instr[10]) begin
                    data.load.ram_load      = instr[9:7] == 3'd0;
                    data.load.xaau_ram_load = instr[9:7] == 3'd1;
                    data.dau.dau_ram_load   = instr[9:7] == 3'd2;
                end
                data.dau.pdx_read = op == OP_R_Y;
                data.load.ram_we  = op == OP_Y_R;    // Store to RAM
                regs.rsel         = instr[8:6];
                regs.r_field      = instr[6:4];
                data.yaau         = y_mode;
                seq.pc_halt       = 1'b1;
                seq.two_cycle     = 1'b1;
            end

            OP_F1_Y, OP_F1_AT_Y: begin
                data.dau.dau_dec_en = 1'b1;
                a_sel               = instr[10:9];
                if (instr[11]) begin              // aT=Y stores the accumulator
                    data.dau.st_a1h      = ~instr[10];
                    data.dau.st_a0h      =  instr[10];
                    data.dau.dau_acc_ram = 1'b1;
                end
                data.yaau = y_mode;
            end

            OP_IF_CON: begin
                data.dau.dau_dec_en  = 1'b1;
                data.dau.dau_special = 1'b1;
                a_sel                = instr[10:9];
            end

            OP_ZY: begin
                data.dau.dau_dec_en   = 1'b1;
                data.dau.dau_ram_load = 1'b1;
                regs.rsel             = 3'b100;  // DAU
                regs.r_field          = y_or_yl;
                data.load.ram_we      = 1'b1;
                // Only the zp case, a plain +1
                data.yaau.post_load   = 1'b1;
                data.yaau.inc_sel     = 2'd2;
                seq.pc_halt           = 1'b1;
                seq.two_cycle         = 1'b1;
            end

            OP_F1_XY: begin
                data.dau.dau_dec_en   = 1'b1;
                data.dau.dau_ram_load = 1'b1;
                regs.r_field          = 3'd0;    // x
                data.yaau             = y_mode;
            end

            OP_F1_Y_WR, OP_F1_YK, OP_F1_Y_A0L, OP_F1_Y_A1L: begin
                data.dau.dau_dec_en = 1'b1;
                regs.r_field        = y_or_yl;
                data.yaau           = y_mode;
                case (op)
                    OP_F1_Y_WR: begin
                        data.load.ram_we = 1'b1;
                        regs.rsel        = 3'b100;
                        seq.pc_halt      = 1'b1;
                        seq.two_cycle    = 1'b1;
                    end
                    OP_F1_YK: data.dau.dau_ram_load = 1'b1;
                    default: begin // Accumulator low or high to RAM
                        regs.rsel        = 3'b010;
                        data.dau.acc_sel = 1'b1;
                        data.load.ram_we = 1'b1;
                        a_sel            = {instr[4], ~instr[15]};
                        seq.pc_halt      = 1'b1;
                        seq.two_cycle    = 1'b1;
                    end
                endcase
            end

            default: seq.hit = 1'b0;
        endcase
    end

endmodule

// File: hdl/branch_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch decoder
// Program-flow opcodes: goto/call JA,
// goto B and the if-CON prefix
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module branch_decode
    import dsp16_ctrl_pkg::*;
(
    input  instr_t       instr,
    output branch_ctrl_t br,
    output seq_ctrl_t    seq
);

    opcode_t op;
    logic    jump;      // Two-cycle PC transfer

    assign op = instr[15:11];

    always_comb begin
        br   = '0;
        seq  = '0;
        jump = 1'b0;
        case (op)
            OP_GOTO_JA, OP_GOTO_JA | 5'd1: begin
                br.goto_ja = 1'b1;  // Qualified later by the condition
                jump       = 1'b1;
            end
            OP_CALL_JA, OP_CALL_JA | 5'd1: begin
                br.call_ja = 1'b1;
                jump       = 1'b1;
            end
            OP_GOTO_B: begin
                br.goto_b = 1'b1;
                br.iret   = instr[10:8] == 3'd1; // iret runs even on a failed condition
                jump      = 1'b1;
            end
            OP_CON_BR: begin
                // Bit 10 set is icall, not implemented
                br.con_check = ~instr[10];
                seq.hit      = 1'b1;
            end
            default: ;
        endcase

        if (jump) begin
            seq.hit       = 1'b1;
            seq.pc_halt   = 1'b1;
            seq.two_cycle = 1'b1;
        end
    end

endmodule

// File: hdl/dsp16_ctrl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DSP16 control package
// Instruction word, T-field opcodes
// and the grouped control strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dsp16_ctrl_pkg;

    typedef logic [15:0] instr_t;
    typedef logic [4:0]  opcode_t;     // T field, bits 15:11

    // Forms ending in 0 also cover the odd T value
    localparam opcode_t OP_GOTO_JA   = 5'b00000; // 0000x
    localparam opcode_t OP_SHORT_IMM = 5'b00010; // 0001x
    localparam opcode_t OP_CALL_JA   = 5'b10000; // 1000x
    localparam opcode_t OP_GOTO_B    = 5'b11000; // ret, iret, goto/call pt
    localparam opcode_t OP_AT_R      = 5'b01000;
    localparam opcode_t OP_R_A0      = 5'b01001;
    localparam opcode_t OP_R_A1      = 5'b01011;
    localparam opcode_t OP_R_IMM     = 5'b01010; // Long immediate
    localparam opcode_t OP_R_Y       = 5'b01111;
    localparam opcode_t OP_Y_R       = 5'b01100;
    localparam opcode_t OP_F1_Y      = 5'b00110;
    localparam opcode_t OP_F1_AT_Y   = 5'b00111;
    localparam opcode_t OP_IF_CON    = 5'b10011; // if CON F2
    localparam opcode_t OP_ZY        = 5'b10101;
    localparam opcode_t OP_F1_XY     = 5'b10110; // F1, x=Y
    localparam opcode_t OP_F1_Y_WR   = 5'b10100; // F1, Y=y
    localparam opcode_t OP_F1_YK     = 5'b10111; // F1, y[k]=Y
    localparam opcode_t OP_F1_Y_A0L  = 5'b11100;
    localparam opcode_t OP_F1_Y_A1L  = 5'b00100;
    localparam opcode_t OP_CON_BR    = 5'b11010; // Conditional branch prefix

    typedef struct packed {
        logic hit;        // Opcode claimed by this decoder
        logic pc_halt;
        logic two_cycle;
    } seq_ctrl_t;

    typedef struct packed {
        logic goto_ja;
        logic goto_b;
        logic call_ja;
        logic con_check;
        logic iret;
    } branch_ctrl_t;

    // Y pointer post-modify
    typedef struct packed {
        logic       post_load;
        logic [1:0] inc_sel;
        logic       step_sel;
        logic       ksel;
    } yaau_ctrl_t;

    typedef struct packed {
        logic short_load;
        logic long_load;
        logic ram_load;
        logic acc_load;
        logic ram_we;
        logic xaau_ram_load;
        logic xaau_imm_load;
        logic xaau_acc_load;
    } load_ctrl_t;

    typedef struct packed {
        logic dau_dec_en;
        logic dau_rmux_load;
        logic dau_imm_load;
        logic dau_ram_load;
        logic dau_acc_load;
        logic dau_fully_load;
        logic dau_acc_ram;
        logic dau_special;
        logic st_a0h;
        logic st_a1h;
        logic acc_sel;
        logic pdx_read;
    } dau_ctrl_t;

    typedef struct packed {
        load_ctrl_t load;
        dau_ctrl_t  dau;
        yaau_ctrl_t yaau;
    } data_ctrl_t;

    typedef struct packed {
        logic [2:0] r_field;
        logic [2:0] rsel;     // Register mux source unit
    } reg_sel_t;

    typedef struct packed {
        opcode_t     t_field;
        logic [4:0]  c_field;
        logic [1:0]  y_field;
        logic [1:0]  a_field;
        logic [5:0]  dau_op_fields;
        logic [8:0]  short_imm;
        logic [11:0] i_field;
        logic [15:0] long_imm;
        reg_sel_t    regs;
    } instr_fields_t;

endpackage
